/* files.f */
source/mem_cfg_pkg.sv
source/mem_tile_pkg.sv
source/iob_ram_2p.sv
source/iob_ram_2p_tiled.sv
source/scratch_ram_top.sv
sim/iob_ram_2p_tiled_properties.sv
sim/scratch_ram_tb.sv

/* sim/scratch_ram_tb.sv */
`timescale 1ns/1ps

// testbench for scratch_ram_top
// reference array tracks every write, reads checked one cycle later
module scratch_ram_tb;

   localparam int DATA_W       = mem_cfg_pkg::DATA_W_DEF;
   localparam int ADDR_W       = mem_cfg_pkg::ADDR_W_DEF;
   localparam int TILE_ADDR_W  = mem_cfg_pkg::TILE_ADDR_W_DEF;
   localparam int TILES        = 2 ** (ADDR_W - TILE_ADDR_W);
   localparam int TILE_WORDS   = 2 ** TILE_ADDR_W;
   localparam int DEPTH        = 2 ** ADDR_W;
   localparam int RESET_CYCLES = 4;
   localparam int POOL_N       = 8 * TILES;  // random test address pool
   localparam int RAND_CYCLES  = 500;

   // cycles per test, each one ends with a flush cycle
   localparam int TEST_CYCLES = RESET_CYCLES
                              + 5                       // reset
                              + 4 * TILES + 1           // write then read
                              + 3 * TILES + 1           // tile isolation
                              + 8                       // hold, masked write
                              + 4                       // collision
                              + POOL_N + RAND_CYCLES + 1;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

   logic              clk_i;
   logic              rst_n_i;
   logic              w_en_i;
   logic              r_en_i;
   logic [DATA_W-1:0] w_data_i;
   logic [ADDR_W-1:0] addr_i;
   logic [DATA_W-1:0] r_data_o;

   logic [DATA_W-1:0] ref_mem [DEPTH];  // reference contents
   bit                written [DEPTH];  // word holds a known value
   logic [DATA_W-1:0] exp_data;         // what r_data_o should show now
   bit                exp_known;
   string             test_name = "init";
   int                test_errs;
   int                test_checks;
   int                pass_tests  = 0;
   int                fail_tests  = 0;
   int                cycle_cnt   = 0;

   scratch_ram_top #(
      .DATA_W      (DATA_W),
      .ADDR_W      (ADDR_W),
      .TILE_ADDR_W (TILE_ADDR_W)
   ) UUT (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_en_i),
      .r_en_i   (r_en_i),
      .w_data_i (w_data_i),
      .addr_i   (addr_i),
      .r_data_o (r_data_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;  // 10 ns period
   end

   // run limit
   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT) begin
         $display("timeout, %0d cycles passed and test %s never finished",
                  cycle_cnt, test_name);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // compare output against the expected word, mid cycle
   task automatic check_output();
      if (exp_known) begin
         test_checks++;
         assert (r_data_o === exp_data) else begin
            $display("FAILED %s: expected %h, actual %h", test_name, exp_data, r_data_o);
            test_errs++;
         end
      end
   endtask

   // one clock of stimulus plus the check of the previous cycle's read
   task automatic run_cycle(input logic we, input logic re,
                            input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      @(posedge clk_i);
      w_en_i   <= we;
      r_en_i   <= re;
      addr_i   <= a;
      w_data_i <= d;
      @(negedge clk_i);
      check_output();   // output now reflects the op driven one cycle ago
      if (re) begin
         exp_data  = ref_mem[a];  // model read before write, read-first
         exp_known = written[a];
      end
      if (we) begin
         ref_mem[a] = d;
         written[a] = 1'b1;
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errs   = 0;
      test_checks = 0;
   endtask

   task automatic end_test();
      run_cycle(1'b0, 1'b0, '0, '0);  // flush the last read
      if (test_errs == 0) begin
         pass_tests++;
         $display("test %s ok, %0d checks", test_name, test_checks);
      end else begin
         fail_tests++;
         $display("test %s: %0d of %0d checks wrong", test_name, test_errs, test_checks);
      end
   endtask

   initial begin : main_seq
      logic [ADDR_W-1:0] a;
      logic [DATA_W-1:0] d;
      logic [ADDR_W-1:0] pool [POOL_N];
      int                idx;
      int                prop_fails;

      void'($urandom(60));  // single seed for the run
      rst_n_i   = 1'b0;
      w_en_i    = 1'b0;
      r_en_i    = 1'b0;
      w_data_i  = '0;
      addr_i    = '0;
      exp_data  = '0;  // output cleared by reset
      exp_known = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_i);
      rst_n_i <= 1'b1;

      // zero after reset, read of an unwritten word first
      start_test("reset");
      a = ADDR_W'(TILE_WORDS + 7);
      run_cycle(1'b0, 1'b0, '0, '0);
      run_cycle(1'b0, 1'b1, a, '0);       // still zero while strobe is sampled
      run_cycle(1'b1, 1'b1, a, DATA_W'(32'h5a5a_c3c3));  // old word, unknown
      run_cycle(1'b0, 1'b1, a, '0);
      end_test();

      // first and last word of every tile
      start_test("write_read");
      for (int t = 0; t < TILES; t++) begin
         run_cycle(1'b1, 1'b0, ADDR_W'(t * TILE_WORDS), DATA_W'($urandom));
         run_cycle(1'b1, 1'b0, ADDR_W'(t * TILE_WORDS + TILE_WORDS - 1), DATA_W'($urandom));
      end
      for (int t = 0; t < TILES; t++) begin
         run_cycle(1'b0, 1'b1, ADDR_W'(t * TILE_WORDS), '0);
         run_cycle(1'b0, 1'b1, ADDR_W'(t * TILE_WORDS + TILE_WORDS - 1), '0);
      end
      end_test();

      // same offset, different word per tile
      start_test("isolation");
      for (int t = 0; t < TILES; t++) begin
         run_cycle(1'b1, 1'b0, ADDR_W'(t * TILE_WORDS + 'h2a5),
                   DATA_W'((t + 1) * 32'h0101_0101));
      end
      for (int t = 0; t < TILES; t++) begin
         run_cycle(1'b0, 1'b1, ADDR_W'(t * TILE_WORDS + 'h2a5), '0);
      end
      for (int t = TILES - 1; t >= 0; t--) begin  // reverse order, select must follow
         run_cycle(1'b0, 1'b1, ADDR_W'(t * TILE_WORDS + 'h2a5), '0);
      end
      end_test();

      // output holds, w_en_i low leaves memory alone
      start_test("hold_mask");
      a = ADDR_W'('h100);
      d = DATA_W'(32'h1234_abcd);
      run_cycle(1'b1, 1'b0, a, d);
      run_cycle(1'b0, 1'b1, a, '0);
      repeat (3) run_cycle(1'b0, 1'b0, a, ~d);   // hold, junk on w_data_i
      run_cycle(1'b0, 1'b0, a, ~d);
      run_cycle(1'b0, 1'b1, a, ~d);              // masked write, original word back
      end_test();

      // read and write on one address, same edge
      start_test("collision");
      a = ADDR_W'((TILES - 1) * TILE_WORDS + TILE_WORDS / 2);
      run_cycle(1'b1, 1'b0, a, DATA_W'(32'haaaa_0001));
      run_cycle(1'b1, 1'b1, a, DATA_W'(32'h5555_0002));  // old word expected
      run_cycle(1'b0, 1'b1, a, '0);                      // new word expected
      end_test();

      // random strobes over a written address pool
      start_test("random");
      for (int i = 0; i < POOL_N; i++) begin
         pool[i] = ADDR_W'((i % TILES) * TILE_WORDS + ($urandom % TILE_WORDS));
         run_cycle(1'b1, 1'b0, pool[i], DATA_W'($urandom));
      end
      for (int k = 0; k < RAND_CYCLES; k++) begin
         if (k < RAND_CYCLES / 2) begin
            idx = int'($urandom % (POOL_N / TILES)) * TILES + k % TILES;  // tile steps
         end else begin
            idx = int'($urandom % POOL_N);
         end
         run_cycle(1'($urandom % 2), ($urandom % 4) != 0, pool[idx], DATA_W'($urandom));
      end
      end_test();

      prop_fails = UUT.u_mem.u_props.fail_cnt;  // bound assertion failures
      $display("tests passed %0d, failed %0d, assertion failures %0d",
               pass_tests, fail_tests, prop_fails);
      if (fail_tests == 0 && prop_fails == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* sim/iob_ram_2p_tiled_properties.sv */
`timescale 1ns/1ps

// concurrent checks on the tiled memory
// bound into every iob_ram_2p_tiled instance by the bind below
module iob_ram_2p_tiled_properties #(
   parameter int DATA_W      = 32,
   parameter int ADDR_W      = 13,
   parameter int TILE_ADDR_W = 11
) (
   input logic                                 clk_i,
   input logic                                 rst_n_i,
   input logic                                 r_en_i,
   input logic [DATA_W-1:0]                    r_data_i,     // tiled r_data_o
   input logic [ADDR_W-TILE_ADDR_W-1:0]        tile_idx_i,   // decoded index this cycle
   input logic [2**(ADDR_W-TILE_ADDR_W)-1:0]   tile_w_en_i,  // gated write strobes
   input logic [ADDR_W-TILE_ADDR_W-1:0]        tile_sel_i    // registered mux select
);

   int fail_cnt = 0;  // failed assertion count

   // a reset cycle leaves a zero word on the output
   a_reset_zero: assert property (@(posedge clk_i) !rst_n_i |=> r_data_i == '0)
      else begin
         $error("r_data_o not zero in the cycle after reset");
         fail_cnt++;
      end

   // no read strobe -> output word holds
   a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !r_en_i |=> $stable(r_data_i))
      else begin
         $error("r_data_o changed without a read strobe");
         fail_cnt++;
      end

   // decode is one-hot, so at most one tile may write
   a_one_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(tile_w_en_i))
      else begin
         $error("more than one tile write enable active");
         fail_cnt++;
      end

   // mux select follows the tile of the last read
   a_sel_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_en_i |=> tile_sel_i == $past(tile_idx_i))
      else begin
         $error("registered tile select does not match the tile that was read");
         fail_cnt++;
      end

endmodule

bind iob_ram_2p_tiled iob_ram_2p_tiled_properties #(
   .DATA_W      (DATA_W),
   .ADDR_W      (ADDR_W),
   .TILE_ADDR_W (TILE_ADDR_W)
) u_props (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .r_en_i      (r_en_i),
   .r_data_i    (r_data_o),
   .tile_idx_i  (tile_idx),
   .tile_w_en_i (tile_w_en),
   .tile_sel_i  (tile_sel_q)
);

/* source/scratch_ram_top.sv */
`timescale 1ns/1ps

// scratch memory top level
// fixes the memory geometry and exposes the single shared port
// write: w_en_i high at an edge stores w_data_i at addr_i on that edge
// read:  r_en_i high at an edge, r_data_o valid the following cycle
module scratch_ram_top #(
   parameter int DATA_W      = mem_cfg_pkg::DATA_W_DEF,      // word width
   parameter int ADDR_W      = mem_cfg_pkg::ADDR_W_DEF,      // word address width
   parameter int TILE_ADDR_W = mem_cfg_pkg::TILE_ADDR_W_DEF  // per-tile address width
) (
   input  logic              clk_i,
   input  logic              rst_n_i,   // sync, active low

   // shared memory port
   input  logic              w_en_i,    // write strobe
   input  logic              r_en_i,    // read strobe
   input  logic [DATA_W-1:0] w_data_i,
   input  logic [ADDR_W-1:0] addr_i,    // word address, read and write
   output logic [DATA_W-1:0] r_data_o   // registered read data
);

   // tiled memory, geometry passed straight down
   iob_ram_2p_tiled #(
      .DATA_W      (DATA_W),
      .ADDR_W      (ADDR_W),
      .TILE_ADDR_W (TILE_ADDR_W)
   ) u_mem (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_en_i),
      .r_en_i   (r_en_i),
      .w_data_i (w_data_i),
      .addr_i   (addr_i),
      .r_data_o (r_data_o)
   );

endmodule

/* source/iob_ram_2p_tiled.sv */
`timescale 1ns/1ps

// one flat address space built from 2**(ADDR_W-TILE_ADDR_W) equal tiles
// upper address bits pick the tile, lower bits the word inside it
// shared address for read and write, registered read, latency 1
module iob_ram_2p_tiled #(
   parameter int DATA_W      = 32,  // word width
   parameter int ADDR_W      = 13,  // full word address width
   parameter int TILE_ADDR_W = 11   // in-tile address width
) (
   input  logic              clk_i,
   input  logic              rst_n_i,   // sync, active low
   input  logic              w_en_i,    // write strobe
   input  logic              r_en_i,    // read strobe
   input  logic [DATA_W-1:0] w_data_i,  // word to write
   input  logic [ADDR_W-1:0] addr_i,    // shared read/write address
   output logic [DATA_W-1:0] r_data_o   // read word, one cycle after r_en_i
);

   localparam int IDX_W      = ADDR_W - TILE_ADDR_W;  // tile index bits
   localparam int TILE_CNT   = 2 ** IDX_W;            // number of tiles
   localparam int TILE_WORDS = 2 ** TILE_ADDR_W;      // depth of each tile

   // elaboration checks on the tile geometry
   if (ADDR_W <= TILE_ADDR_W) begin : g_err_split
      $error("iob_ram_2p_tiled: ADDR_W (%0d) must exceed TILE_ADDR_W (%0d)",
             ADDR_W, TILE_ADDR_W);
   end
   if (TILE_WORDS > mem_tile_pkg::TILE_WORDS_MAX) begin : g_err_depth
      $error("iob_ram_2p_tiled: tile depth %0d above limit %0d",
             TILE_WORDS, mem_tile_pkg::TILE_WORDS_MAX);
   end
   if (TILE_CNT > mem_tile_pkg::MAX_TILES) begin : g_err_count
      $error("iob_ram_2p_tiled: tile count %0d above limit %0d",
             TILE_CNT, mem_tile_pkg::MAX_TILES);
   end

   // address split
   logic [IDX_W-1:0]       tile_idx;  // which tile this cycle
   logic [TILE_ADDR_W-1:0] tile_off;  // word inside the tile

   assign tile_idx = addr_i[ADDR_W-1 -: IDX_W];
   assign tile_off = addr_i[TILE_ADDR_W-1:0];

   // one-hot tile decode
   logic [TILE_CNT-1:0] tile_en;

   always_comb begin
      tile_en           = '0;
      tile_en[tile_idx] = 1'b1;  // exactly one tile bit set
   end

   // strobes gated per tile, only the addressed tile sees them
   logic [TILE_CNT-1:0] tile_w_en;
   logic [TILE_CNT-1:0] tile_r_en;

   assign tile_w_en = {TILE_CNT{w_en_i}} & tile_en;
   assign tile_r_en = {TILE_CNT{r_en_i}} & tile_en;

   // read words coming back from every tile
   logic [DATA_W-1:0] tile_r_data [TILE_CNT];

   // tile array
   for (genvar t = 0; t < TILE_CNT; t++) begin : g_tile
      iob_ram_2p #(
         .DATA_W (DATA_W),
         .ADDR_W (TILE_ADDR_W)
      ) u_ram (
         .clk_i    (clk_i),
         .rst_n_i  (rst_n_i),
         .w_en_i   (tile_w_en[t]),
         .w_addr_i (tile_off),      // same offset both ports
         .w_data_i (w_data_i),
         .r_en_i   (tile_r_en[t]),
         .r_addr_i (tile_off),
         .r_data_o (tile_r_data[t])
      );
   end

   // registered select
   // captured with the read so the mux follows the tile that was read,
   // not whatever addr_i shows in the data cycle
   logic [IDX_W-1:0] tile_sel_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         tile_sel_q <= '0;  // points at tile 0 after reset
      end else if (r_en_i) begin
         tile_sel_q <= tile_idx;
      end
   end

   // output mux
   // holds with r_en_i low since both the tile reg and tile_sel_q hold
   always_comb begin
      r_data_o = tile_r_data[tile_sel_q];
   end

endmodule

/* source/iob_ram_2p.sv */
`timescale 1ns/1ps

// single block-RAM tile, one write port and one read port
// read data is registered, valid the cycle after r_en_i
// same-address read and write in one cycle returns the old word
module iob_ram_2p #(
   parameter int DATA_W = 32,  // word width
   parameter int ADDR_W = 11   // word address width, depth is 2**ADDR_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,   // sync, active low, clears read reg only

   // write port
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,

   // read port
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o   // registered read word
);

   localparam int DEPTH = 2 ** ADDR_W;  // words in this tile

   // storage array, inferred as block RAM
   logic [DATA_W-1:0] mem [DEPTH];

   // write port
   always_ff @(posedge clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;  // lands on this edge
      end
   end

   // read port with output register
   // nonblocking read of mem sees the value before this edge's write,
   // which gives read-first on an address collision
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         r_data_o <= '0;  // known output after reset
      end else if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
      // no r_en_i -> register holds last word
   end

endmodule

/* source/mem_tile_pkg.sv */
// physical limits of one block-RAM tile and of the tile array
// checked by the tiled memory at elaboration time
package mem_tile_pkg;

   // deepest single tile that still maps onto one block RAM
   // 2**11 words
   localparam int TILE_WORDS_MAX = 2048;

   // cap on how many tiles one tiled memory may instantiate
   // keeps the output mux and the one-hot decode small
   localparam int MAX_TILES = 64;

   // a tiled memory is legal when
   //   2**TILE_ADDR_W               <= TILE_WORDS_MAX
   //   2**(ADDR_W - TILE_ADDR_W)    <= MAX_TILES

endpackage

/* source/mem_cfg_pkg.sv */
// default build values for the scratch memory
// the top level picks these up as parameter defaults, the testbench
// reads them to size its reference array and address ranges
package mem_cfg_pkg;

   // width of one data word in bits
   localparam int DATA_W_DEF = 32;

   // full word-address width of the shared port
   // 13 bits -> 8192 words in total
   localparam int ADDR_W_DEF = 13;

   // low address bits that index a word inside one tile
   // 11 bits -> 2048 words per tile
   // the remaining upper bits (ADDR_W_DEF - TILE_ADDR_W_DEF) pick the tile,
   // so the default build has 4 tiles
   localparam int TILE_ADDR_W_DEF = 11;

   // address layout, msb to lsb:
   //   [ADDR_W-1 : TILE_ADDR_W]  tile index
   //   [TILE_ADDR_W-1 : 0]       word offset in tile

endpackage
